// File: logic/bus_proto_pkg.sv
`default_nettype none

package bus_proto_pkg;

    localparam int addr_w = 15;
    localparam int data_w = 8;
    localparam int len_w  = 4;  // bit count field, up to 15 bits

    // two-sample line patterns, older sample in bit 1
    localparam logic [1:0] addr_ack_prefix = 2'b00;
    localparam logic [1:0] data_ack_prefix = 2'b01;  // also the read start prefix

    // byte sits in the top bits so it leaves the shifter MSB first
    typedef struct packed
    {
        logic [data_w-1:0]        data;
        logic [addr_w-data_w-1:0] pad;
    } data_frame_t;

    typedef union packed
    {
        logic [addr_w-1:0] addr;
        data_frame_t       frame;
    } shift_word_t;

endpackage

`default_nettype wire

// File: logic/master_ctrl_pkg.sv
`default_nettype none

package master_ctrl_pkg;

    typedef enum logic [3:0]
    {
        st_idle,
        st_requested,
        st_granted,
        st_addr_send,
        st_addr_ack_wait,
        st_retry,          // bus released, waiting for regrant
        st_read_wait,
        st_read_shift,
        st_write_send,
        st_data_ack_wait
    } ctrl_state_t;

    // msb marks the bus release point, all ones the retry point
    localparam int timeout_w = 6;

endpackage

`default_nettype wire

// File: logic/master_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module master_ctrl
(
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             hold,
    input  wire                             execute,
    input  wire                             grant,
    input  wire                             rw_latched,
    input  wire                             tx_done,
    input  wire                             rx_done,
    input  wire                             addr_ack,
    input  wire                             data_ack,
    input  wire                             release_bus,
    input  wire                             expired,
    output logic                            request,
    output logic                            busy,
    output logic                            done,
    output logic                            bus_util,
    output logic                            load,
    output logic                            frame_sel,
    output logic                            tx_start,
    output logic                            rx_start,
    output logic [bus_proto_pkg::len_w-1:0] bit_len,
    output logic                            watch,
    output logic                            tmo_clear
);

    master_ctrl_pkg::ctrl_state_t state_q;
    logic                         ack_taken;

    // acknowledge only counts before the release point
    assign ack_taken = (state_q == master_ctrl_pkg::st_addr_ack_wait) && addr_ack && !release_bus;

    always_comb
    begin
        load      = 1'b0;
        tx_start  = 1'b0;
        rx_start  = 1'b0;
        frame_sel = 1'b0;
        watch     = 1'b0;
        tmo_clear = 1'b1;  // counter and line history held clear by default
        bit_len   = bus_proto_pkg::len_w'(bus_proto_pkg::addr_w);
        case (state_q)
            master_ctrl_pkg::st_granted:
            begin
                load     = hold & execute;
                tx_start = hold & execute;
            end
            master_ctrl_pkg::st_retry:
                tx_start = grant;  // resend same address
            master_ctrl_pkg::st_addr_ack_wait:
            begin
                watch     = 1'b1;
                frame_sel = 1'b1;
                bit_len   = bus_proto_pkg::len_w'(bus_proto_pkg::data_w);
                tmo_clear = ack_taken;  // restart line history for the next prefix
                tx_start  = ack_taken & rw_latched;
            end
            master_ctrl_pkg::st_read_wait:
            begin
                watch     = grant;
                tmo_clear = 1'b0;
                bit_len   = bus_proto_pkg::len_w'(bus_proto_pkg::data_w);
                rx_start  = grant & data_ack;
            end
            master_ctrl_pkg::st_data_ack_wait:
            begin
                watch     = grant;
                tmo_clear = 1'b0;
            end
            default:
            begin
                tmo_clear = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state_q  <= master_ctrl_pkg::st_idle;
            request  <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            bus_util <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state_q)
                master_ctrl_pkg::st_idle:
                begin
                    request <= hold;
                    if (hold)
                        state_q <= master_ctrl_pkg::st_requested;
                end
                master_ctrl_pkg::st_requested:
                begin
                    if (grant)
                    begin
                        bus_util <= 1'b1;
                        state_q  <= master_ctrl_pkg::st_granted;
                    end
                end
                master_ctrl_pkg::st_granted:
                begin
                    if (!hold)
                    begin
                        request  <= 1'b0;
                        bus_util <= 1'b0;
                        state_q  <= master_ctrl_pkg::st_idle;
                    end
                    else if (execute)
                    begin
                        busy    <= 1'b1;
                        state_q <= master_ctrl_pkg::st_addr_send;
                    end
                end
                master_ctrl_pkg::st_addr_send:
                    if (tx_done)
                        state_q <= master_ctrl_pkg::st_addr_ack_wait;
                master_ctrl_pkg::st_addr_ack_wait:
                begin
                    if (expired)
                    begin
                        request <= 1'b1;  // ask again for the resend
                        state_q <= master_ctrl_pkg::st_retry;
                    end
                    else if (release_bus)
                    begin
                        request  <= 1'b0;
                        bus_util <= 1'b0;
                    end
                    else if (ack_taken)
                    begin
                        state_q <= rw_latched ? master_ctrl_pkg::st_write_send
                                              : master_ctrl_pkg::st_read_wait;
                    end
                end
                master_ctrl_pkg::st_retry:
                begin
                    if (grant)
                    begin
                        bus_util <= 1'b1;
                        state_q  <= master_ctrl_pkg::st_addr_send;
                    end
                end
                master_ctrl_pkg::st_write_send:
                    if (tx_done)
                        state_q <= master_ctrl_pkg::st_data_ack_wait;
                master_ctrl_pkg::st_data_ack_wait:
                begin
                    bus_util <= grant;  // off the bus while grant is away
                    if (grant && data_ack)
                    begin
                        done    <= 1'b1;
                        busy    <= 1'b0;
                        state_q <= master_ctrl_pkg::st_granted;
                    end
                end
                master_ctrl_pkg::st_read_wait:
                begin
                    bus_util <= grant;
                    if (grant && data_ack)
                        state_q <= master_ctrl_pkg::st_read_shift;
                end
                master_ctrl_pkg::st_read_shift:
                begin
                    if (rx_done)
                    begin
                        done    <= 1'b1;
                        busy    <= 1'b0;
                        state_q <= master_ctrl_pkg::st_granted;
                    end
                end
                default:
                    state_q <= master_ctrl_pkg::st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/txn_regs.sv
`timescale 1ns/100ps
`default_nettype none

module txn_regs
(
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              load,
    input  wire                              frame_sel,
    input  wire                              rx_done,
    input  wire  [bus_proto_pkg::data_w-1:0] rx_byte,
    input  wire                              rw,
    input  wire  [bus_proto_pkg::addr_w-1:0] address,
    input  wire  [bus_proto_pkg::data_w-1:0] wdata,
    output logic                             rw_latched,
    output bus_proto_pkg::shift_word_t       tx_word,
    output logic [bus_proto_pkg::data_w-1:0] rdata
);

    logic [bus_proto_pkg::addr_w-1:0] addr_q;
    logic [bus_proto_pkg::data_w-1:0] wdata_q;

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            addr_q  <= address;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            rw_latched <= 1'b0;
            rdata      <= '0;
        end
        else
        begin
            if (load)
                rw_latched <= rw;
            if (rx_done)
                rdata <= rx_byte;
        end
    end

    // address passes straight through on load so the shifter starts at once
    always_comb
    begin
        tx_word.addr = load ? address : addr_q;
        if (frame_sel)
        begin
            tx_word.frame.data = wdata_q;
            tx_word.frame.pad  = '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/serial_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module serial_shifter
(
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              tx_start,
    input  wire                              rx_start,
    input  wire  [bus_proto_pkg::len_w-1:0]  bit_len,
    input  bus_proto_pkg::shift_word_t       tx_word,
    input  wire                              bus_in,
    output logic                             bus_out,
    output logic                             bus_oe,
    output logic                             tx_done,
    output logic                             rx_done,
    output logic [bus_proto_pkg::data_w-1:0] rx_byte
);

    bus_proto_pkg::shift_word_t      shift_q;
    bus_proto_pkg::shift_word_t      rx_next;
    logic [bus_proto_pkg::len_w-1:0] cnt_q;  // bits left
    logic                            rx_act_q;

    assign bus_out = bus_oe & shift_q.addr[bus_proto_pkg::addr_w-1];
    assign tx_done = bus_oe && (cnt_q == 1);
    assign rx_done = rx_act_q && (cnt_q == 1);

    // received bits collect in the byte field of the frame view
    always_comb
    begin
        rx_next            = shift_q;
        rx_next.frame.data = {shift_q.frame.data[bus_proto_pkg::data_w-2:0], bus_in};
    end

    assign rx_byte = rx_next.frame.data;  // complete during the last bit

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bus_oe   <= 1'b0;
            rx_act_q <= 1'b0;
            cnt_q    <= '0;
        end
        else if (tx_start)
        begin
            bus_oe <= 1'b1;
            cnt_q  <= bit_len;
        end
        else if (rx_start)
        begin
            rx_act_q <= 1'b1;
            cnt_q    <= bit_len;
        end
        else if (bus_oe || rx_act_q)
        begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == 1)
            begin
                bus_oe   <= 1'b0;
                rx_act_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_start)
            shift_q <= tx_word;
        else if (rx_start)
            shift_q <= '0;
        else if (bus_oe)
            shift_q.addr <= {shift_q.addr[bus_proto_pkg::addr_w-2:0], 1'b0};  // msb first
        else if (rx_act_q)
            shift_q <= rx_next;
    end

endmodule

`default_nettype wire

// File: logic/ack_watch.sv
`timescale 1ns/100ps
`default_nettype none

module ack_watch
(
    input  wire  clk,
    input  wire  rstn,
    input  wire  watch,
    input  wire  tmo_clear,
    input  wire  bus_in,
    output logic addr_ack,
    output logic data_ack,
    output logic release_bus,
    output logic expired
);

    logic                                  prev_q;  // last line sample, 1 when idle
    logic [master_ctrl_pkg::timeout_w-1:0] tmo_q;

    assign addr_ack = watch && ({prev_q, bus_in} == bus_proto_pkg::addr_ack_prefix);
    assign data_ack = watch && ({prev_q, bus_in} == bus_proto_pkg::data_ack_prefix);

    assign release_bus = tmo_q[master_ctrl_pkg::timeout_w-1];  // half window
    assign expired     = &tmo_q;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            prev_q <= 1'b1;
            tmo_q  <= '0;
        end
        else if (tmo_clear)
        begin
            prev_q <= 1'b1;
            tmo_q  <= '0;
        end
        else
        begin
            prev_q <= watch ? bus_in : 1'b1;
            if (watch)
                tmo_q <= tmo_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/bus_master_top.sv
`timescale 1ns/100ps
`default_nettype none

module bus_master_top
(
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              hold,
    input  wire                              execute,
    input  wire                              rw,
    input  wire  [bus_proto_pkg::addr_w-1:0] address,
    input  wire  [bus_proto_pkg::data_w-1:0] wdata,
    output logic [bus_proto_pkg::data_w-1:0] rdata,
    output logic                             done,
    output logic                             busy,
    input  wire                              grant,
    output logic                             request,
    input  wire                              bus_in,
    output logic                             bus_out,
    output logic                             bus_oe,
    output logic                             bus_rw,
    output logic                             bus_util
);

    logic                             load;
    logic                             frame_sel;
    logic                             tx_start;
    logic                             rx_start;
    logic [bus_proto_pkg::len_w-1:0]  bit_len;
    logic                             watch;
    logic                             tmo_clear;
    logic                             tx_done;
    logic                             rx_done;
    logic [bus_proto_pkg::data_w-1:0] rx_byte;
    logic                             addr_ack;
    logic                             data_ack;
    logic                             release_bus;
    logic                             expired;
    logic                             rw_latched;
    bus_proto_pkg::shift_word_t       tx_word;

    // rw line only driven while this master owns the bus
    assign bus_rw = rw_latched & bus_util;

    master_ctrl u_ctrl
    (
        .clk         (clk),
        .rstn        (rstn),
        .hold        (hold),
        .execute     (execute),
        .grant       (grant),
        .rw_latched  (rw_latched),
        .tx_done     (tx_done),
        .rx_done     (rx_done),
        .addr_ack    (addr_ack),
        .data_ack    (data_ack),
        .release_bus (release_bus),
        .expired     (expired),
        .request     (request),
        .busy        (busy),
        .done        (done),
        .bus_util    (bus_util),
        .load        (load),
        .frame_sel   (frame_sel),
        .tx_start    (tx_start),
        .rx_start    (rx_start),
        .bit_len     (bit_len),
        .watch       (watch),
        .tmo_clear   (tmo_clear)
    );

    txn_regs u_regs
    (
        .clk        (clk),
        .rstn       (rstn),
        .load       (load),
        .frame_sel  (frame_sel),
        .rx_done    (rx_done),
        .rx_byte    (rx_byte),
        .rw         (rw),
        .address    (address),
        .wdata      (wdata),
        .rw_latched (rw_latched),
        .tx_word    (tx_word),
        .rdata      (rdata)
    );

    serial_shifter u_shift
    (
        .clk      (clk),
        .rstn     (rstn),
        .tx_start (tx_start),
        .rx_start (rx_start),
        .bit_len  (bit_len),
        .tx_word  (tx_word),
        .bus_in   (bus_in),
        .bus_out  (bus_out),
        .bus_oe   (bus_oe),
        .tx_done  (tx_done),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte)
    );

    ack_watch u_ack
    (
        .clk         (clk),
        .rstn        (rstn),
        .watch       (watch),
        .tmo_clear   (tmo_clear),
        .bus_in      (bus_in),
        .addr_ack    (addr_ack),
        .data_ack    (data_ack),
        .release_bus (release_bus),
        .expired     (expired)
    );

endmodule

`default_nettype wire

// File: tb/bus_checker.sv
`timescale 1ns/100ps
`default_nettype none

module bus_checker
(
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              hold,
    input  wire                              execute,
    input  wire                              rw,
    input  wire  [bus_proto_pkg::addr_w-1:0] address,
    input  wire  [bus_proto_pkg::data_w-1:0] wdata,
    input  wire  [bus_proto_pkg::data_w-1:0] slave_byte,
    input  wire                              grant,
    input  wire                              request,
    input  wire                              busy,
    input  wire                              done,
    input  wire  [bus_proto_pkg::data_w-1:0] rdata,
    input  wire                              bus_in,
    input  wire                              bus_out,
    input  wire                              bus_oe,
    input  wire                              bus_rw,
    input  wire                              bus_util,
    output int                               errors,
    output int                               checks
);

    // bus ownership as seen from the ports
    localparam int ms_idle = 0;
    localparam int ms_req  = 1;
    localparam int ms_gnt  = 2;
    localparam int ms_act  = 3;  // transaction in flight

    // steps of one transaction
    localparam int ph_addr  = 0;  // address bits on the line
    localparam int ph_ack   = 1;  // acknowledge window running
    localparam int ph_retry = 2;  // request raised again, waiting for grant
    localparam int ph_data  = 3;  // write byte on the line
    localparam int ph_wait  = 4;  // data acknowledge or read start prefix
    localparam int ph_shift = 5;  // read byte coming in

    localparam int release_at = 32;  // counter msb set
    localparam int retry_at   = 63;  // counter all ones

    int                               ms;
    int                               phase;
    int                               nbits;
    int                               tmo;
    int                               rx_left;
    logic                             exp_req;
    logic                             exp_util;
    logic                             exp_done;
    logic                             line_d;  // previous line sample seen by the master
    logic                             lat_rw;
    logic [bus_proto_pkg::addr_w-1:0] lat_addr;
    logic [bus_proto_pkg::data_w-1:0] lat_wdata;
    logic [bus_proto_pkg::data_w-1:0] lat_byte;
    logic [bus_proto_pkg::addr_w-1:0] frame;

    initial
    begin
        errors = 0;
        checks = 0;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic flag(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // bits arrive msb first while bus_oe is high
    task automatic collect_bit;
        if (bus_oe)
        begin
            frame = {frame[bus_proto_pkg::addr_w-2:0], bus_out};
            nbits++;
        end
        else if (nbits == bus_proto_pkg::addr_w)
        begin
            compare("address bits", frame, lat_addr);
            nbits  = 0;
            phase  = ph_ack;
            tmo    = 0;
            line_d = 1'b1;
        end
        else if (nbits == bus_proto_pkg::data_w)
        begin
            if (lat_rw)
                compare("write data bits", frame[bus_proto_pkg::data_w-1:0], lat_wdata);
            else
                flag("master drove data bits during a read");
            nbits  = 0;
            phase  = ph_wait;
            line_d = 1'b1;
        end
        else if (nbits != 0)
        begin
            flag("bus_oe pulse had the wrong length");
            nbits = 0;
        end
    endtask

    task automatic advance_txn;
        case (phase)
            ph_ack:
            begin
                if (tmo < release_at && !line_d && !bus_in)
                begin
                    phase  = lat_rw ? ph_data : ph_wait;
                    line_d = 1'b1;
                end
                else
                begin
                    if (tmo == retry_at)
                    begin
                        exp_req = 1'b1;
                        phase   = ph_retry;
                    end
                    else if (tmo >= release_at)
                    begin
                        exp_req  = 1'b0;  // bus given up, busy stays
                        exp_util = 1'b0;
                    end
                    line_d = bus_in;
                    tmo++;
                end
            end
            ph_retry:
                if (grant)
                begin
                    exp_util = 1'b1;
                    phase    = ph_addr;
                end
            ph_wait:
            begin
                exp_util = grant;  // off the bus while grant is away
                if (grant && !line_d && bus_in)
                begin
                    if (lat_rw)
                        exp_done = 1'b1;
                    else
                    begin
                        rx_left = bus_proto_pkg::data_w;
                        phase   = ph_shift;
                    end
                end
                line_d = grant ? bus_in : 1'b1;
            end
            ph_shift:
            begin
                rx_left--;
                if (rx_left == 0)
                    exp_done = 1'b1;
            end
            default:
                ;
        endcase
    endtask

    task automatic step_model;
        case (ms)
            ms_idle:
            begin
                exp_req = hold;  // request follows hold one cycle later
                if (hold)
                    ms = ms_req;
            end
            ms_req:
                if (grant)
                begin
                    exp_util = 1'b1;
                    ms       = ms_gnt;
                end
            ms_gnt:
                if (!hold)
                begin
                    exp_req  = 1'b0;
                    exp_util = 1'b0;
                    ms       = ms_idle;
                end
                else if (execute)
                begin
                    lat_rw    = rw;
                    lat_addr  = address;
                    lat_wdata = wdata;
                    lat_byte  = slave_byte;
                    nbits     = 0;
                    phase     = ph_addr;
                    exp_done  = 1'b0;
                    ms        = ms_act;
                end
        endcase
    endtask

    // samples are the values of the cycle that just ended
    always @(posedge clk)
    begin
        if (!rstn)
        begin
            ms       = ms_idle;
            phase    = ph_addr;
            exp_req  = 1'b0;
            exp_util = 1'b0;
            exp_done = 1'b0;
            line_d   = 1'b1;
            lat_rw   = 1'b0;
            nbits    = 0;
            tmo      = 0;
            rx_left  = 0;
        end
        else
        begin
            compare("bus_rw", bus_rw, lat_rw & exp_util);
            if (ms != ms_act)
            begin
                compare("request", request, exp_req);
                compare("bus_util", bus_util, exp_util);
                compare("busy", busy, 1'b0);
                compare("done", done, 1'b0);
                compare("bus_oe", bus_oe, 1'b0);
            end
            else
            begin
                compare("request", request, exp_req);
                compare("bus_util", bus_util, exp_util);
                compare("done", done, exp_done);
                compare("busy", busy, !exp_done);
                if (exp_done)
                begin
                    if (!lat_rw)
                        compare("rdata", rdata, lat_byte);
                    exp_done = 1'b0;
                    ms       = ms_gnt;
                end
                else
                begin
                    collect_bit();
                    advance_txn();
                end
            end
            step_model();
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bus_master;

    localparam int sel_oe   = 0;
    localparam int sel_req  = 1;
    localparam int sel_util = 2;
    localparam int sel_done = 3;

    logic                             clk;
    logic                             rstn;
    logic                             hold;
    logic                             execute;
    logic                             rw;
    logic [bus_proto_pkg::addr_w-1:0] address;
    logic [bus_proto_pkg::data_w-1:0] wdata;
    logic [bus_proto_pkg::data_w-1:0] rdata;
    logic                             done;
    logic                             busy;
    logic                             grant;
    logic                             request;
    wire                              bus_in;
    logic                             bus_out;
    logic                             bus_oe;
    logic                             bus_rw;
    logic                             bus_util;

    logic                             gap;  // arbiter holds grant back
    logic                             sl_oe;
    logic                             sl_val;
    logic [bus_proto_pkg::data_w-1:0] slave_byte;
    logic [31:0]                      lfsr;
    logic                             timed_out;
    int                               timeouts;
    int                               chk_errors;
    int                               chk_checks;

    // pull-up when neither side drives the line
    assign bus_in = bus_oe ? bus_out : (sl_oe ? sl_val : 1'b1);

    bus_master_top dut
    (
        .clk      (clk),
        .rstn     (rstn),
        .hold     (hold),
        .execute  (execute),
        .rw       (rw),
        .address  (address),
        .wdata    (wdata),
        .rdata    (rdata),
        .done     (done),
        .busy     (busy),
        .grant    (grant),
        .request  (request),
        .bus_in   (bus_in),
        .bus_out  (bus_out),
        .bus_oe   (bus_oe),
        .bus_rw   (bus_rw),
        .bus_util (bus_util)
    );

    bus_checker chk
    (
        .clk        (clk),
        .rstn       (rstn),
        .hold       (hold),
        .execute    (execute),
        .rw         (rw),
        .address    (address),
        .wdata      (wdata),
        .slave_byte (slave_byte),
        .grant      (grant),
        .request    (request),
        .busy       (busy),
        .done       (done),
        .rdata      (rdata),
        .bus_in     (bus_in),
        .bus_out    (bus_out),
        .bus_oe     (bus_oe),
        .bus_rw     (bus_rw),
        .bus_util   (bus_util),
        .errors     (chk_errors),
        .checks     (chk_checks)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // all inputs change just after the falling edge, grant mirrors request
    task automatic tick;
        @(negedge clk);
        grant = rstn && request && !gap;
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            sel_oe:   return bus_oe;
            sel_req:  return request;
            sel_util: return bus_util;
            default:  return done;
        endcase
    endfunction

    task automatic wait_for(input int sel, input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (!timed_out && probe(sel) !== level && n < limit)
        begin
            tick();
            n++;
        end
        if (!timed_out && probe(sel) !== level)
        begin
            timed_out = 1'b1;
            timeouts++;
            $display("Timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    // older bit of the pattern goes on the line first
    task automatic send_prefix(input logic [1:0] p);
        sl_oe  = 1'b1;
        sl_val = p[1];
        tick();
        sl_val = p[0];
        tick();
    endtask

    // a stray prefix inside the gap must not be taken
    task automatic withdraw_grant(input int cycles);
        if (cycles > 0)
        begin
            gap   = 1'b1;
            grant = 1'b0;
            if (cycles > 1)
            begin
                send_prefix(bus_proto_pkg::data_ack_prefix);
                sl_oe = 1'b0;
                repeat (cycles - 2) tick();
            end
            else
                tick();
            gap   = 1'b0;
            grant = request;
            tick();  // bus_util comes back
        end
    endtask

    task automatic run_txn;
        logic [31:0] r;
        logic        withhold;
        logic        extra;
        int          gap_len;
        take_bits(1, r);
        rw = r[0];
        take_bits(bus_proto_pkg::addr_w, r);
        address = r[bus_proto_pkg::addr_w-1:0];
        take_bits(bus_proto_pkg::data_w, r);
        wdata = r[bus_proto_pkg::data_w-1:0];
        take_bits(bus_proto_pkg::data_w, r);
        slave_byte = r[bus_proto_pkg::data_w-1:0];
        take_bits(2, r);
        withhold = (r[1:0] == 2'b00);  // one in four
        take_bits(1, r);
        extra = r[0];
        take_bits(3, r);
        gap_len = r[2:0];
        execute = 1'b1;
        tick();
        execute = extra;  // second strobe lands while busy
        tick();
        execute = 1'b0;
        wait_for(sel_oe, 1'b1, 10, "address phase");
        wait_for(sel_oe, 1'b0, 30, "end of address phase");
        if (withhold)
        begin
            wait_for(sel_req, 1'b0, 80, "request release after missing acknowledge");
            wait_for(sel_req, 1'b1, 80, "request for the address resend");
            wait_for(sel_oe, 1'b1, 20, "resent address");
            wait_for(sel_oe, 1'b0, 30, "end of resent address");
        end
        send_prefix(bus_proto_pkg::addr_ack_prefix);
        sl_oe = 1'b0;
        if (rw)
        begin
            wait_for(sel_oe, 1'b1, 10, "write data phase");
            wait_for(sel_oe, 1'b0, 20, "end of write data phase");
            withdraw_grant(gap_len);
            send_prefix(bus_proto_pkg::data_ack_prefix);
        end
        else
        begin
            withdraw_grant(gap_len);
            send_prefix(bus_proto_pkg::data_ack_prefix);
            for (int i = bus_proto_pkg::data_w - 1; i >= 0; i--)
            begin
                sl_val = slave_byte[i];
                tick();
            end
        end
        sl_oe = 1'b0;
        wait_for(sel_done, 1'b1, 40, "done");
    endtask

    initial
    begin
        rstn       = 1'b0;
        hold       = 1'b0;
        execute    = 1'b0;
        rw         = 1'b0;
        address    = '0;
        wdata      = '0;
        grant      = 1'b0;
        gap        = 1'b0;
        sl_oe      = 1'b0;
        sl_val     = 1'b1;
        slave_byte = '0;
        lfsr       = 32'h8b87_a93a;
        timed_out  = 1'b0;
        timeouts   = 0;
        repeat (3) tick();
        rstn = 1'b1;
        // strobe with no bus ownership
        execute = 1'b1;
        tick();
        execute = 1'b0;
        tick();
        for (int round = 0; round < 2; round++)
        begin
            hold = 1'b1;
            wait_for(sel_util, 1'b1, 10, "bus ownership");
            for (int n = 0; n < 12; n++)
                run_txn();
            hold = 1'b0;
            wait_for(sel_req, 1'b0, 10, "request to drop with hold");
            tick();
        end
        tick();
        $display("checks %0d, mismatches %0d, timeouts %0d", chk_checks, chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/bus_proto_pkg.sv
logic/master_ctrl_pkg.sv
logic/master_ctrl.sv
logic/txn_regs.sv
logic/serial_shifter.sv
logic/ack_watch.sv
logic/bus_master_top.sv
tb/bus_checker.sv
tb/tb_bus_master.sv
